// File: hw/msdapPkg.sv
package msdapPkg;

	////////////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////////////

	typedef logic signed [15:0] sampleT;
	typedef logic [15:0] coeffT;
	typedef logic [39:0] accT;
	typedef logic [10:0] memAddrT;
	typedef logic [7:0] histIdxT;

	////////////////////////////////////////////////////////////
	// Memory map, offsets inside one channel half
	////////////////////////////////////////////////////////////

	localparam memAddrT historyBase = 11'd0;
	localparam memAddrT rjBase = 11'd256;
	localparam memAddrT coeffBase = 11'd512;
	// Right channel lives in the upper half
	localparam memAddrT channelStride = 11'd1024;

	// Coefficient word fields
	localparam int delayWidth = 8;
	localparam int signBit = 8;

	////////////////////////////////////////////////////////////
	// State machines
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {loadRj, loadCoeff, run, asleep} loadStateT;

	typedef enum logic [2:0] {
		idle,
		fetchRj,
		fetchCoeff,
		fetchSample,
		groupEnd,
		nextChannel
	} engineStateT;

endpackage

// File: hw/serialReceiver.sv
`timescale 1ns/1ps

module serialReceiver import msdapPkg::*; (
	input logic sClk,
	input logic reset,
	input logic frame,
	input logic inputL,
	input logic inputR,
	output logic wordValid,
	output sampleT wordL,
	output sampleT wordR
);

	// Bits still expected after the current one
	logic [3:0] bitCnt;
	logic shifting;

	always_ff @(posedge sClk or negedge reset)
	begin
		if (!reset)
		begin
			bitCnt <= '0;
			shifting <= 1'b0;
			wordValid <= 1'b0;
		end
		else
		begin
			// Bit 0 is sampled while the count sits at one
			wordValid <= shifting && (bitCnt == 4'd1) && !frame;
			if (frame)
			begin
				shifting <= 1'b1;
				bitCnt <= 4'd15;
			end
			else if (shifting)
			begin
				bitCnt <= bitCnt - 4'd1;
				if (bitCnt == 4'd1)
					shifting <= 1'b0;
			end
		end
	end

	// MSB arrives first with the frame pulse
	always_ff @(posedge sClk)
	begin
		if (frame || shifting)
		begin
			wordL <= {wordL[14:0], inputL};
			wordR <= {wordR[14:0], inputR};
		end
	end

endmodule

// File: hw/loadSequencer.sv
`timescale 1ns/1ps

module loadSequencer import msdapPkg::*; #(
	parameter int numRj = 16,
	parameter int numCoeff = 512,
	parameter int sleepThreshold = 800
) (
	input logic sClk,
	input logic reset,
	input logic start,
	input logic wordValid,
	input sampleT wordL,
	input sampleT wordR,
	input logic wrGnt,
	input logic engineBusy,
	output logic inReady,
	output logic wrReq,
	output memAddrT wrAddr,
	output sampleT wrData,
	output logic newSample,
	output histIdxT newestIdx,
	output logic historyFull
);

	localparam int cntW = $clog2((numCoeff > numRj ? numCoeff : numRj) + 1);
	localparam int zeroW = $clog2(sleepThreshold + 1);

	loadStateT state;
	logic [cntW-1:0] loadCnt;
	logic [zeroW-1:0] zeroCnt;
	histIdxT sampleIdx;
	logic pendL;
	logic pendR;
	logic isHistory;
	logic issueSample;
	logic zeroPair;
	memAddrT wordAddr;
	memAddrT addrL;
	sampleT holdL;
	sampleT holdR;

	assign zeroPair = (wordL == '0) && (wordR == '0);

	// Left half address of the incoming word
	always_comb
	begin
		case (state)
			loadRj: wordAddr = rjBase + memAddrT'(loadCnt);
			loadCoeff: wordAddr = coeffBase + memAddrT'(loadCnt);
			default: wordAddr = historyBase + memAddrT'(sampleIdx);
		endcase
	end

	// Left write first, the right copy goes one half up
	assign wrReq = pendL | pendR;
	assign wrAddr = pendL ? addrL : addrL + channelStride;
	assign wrData = pendL ? holdL : holdR;

	always_ff @(posedge sClk)
	begin
		if (wordValid)
		begin
			holdL <= wordL;
			holdR <= wordR;
			addrL <= wordAddr;
		end
	end

	always_ff @(posedge sClk or negedge reset)
	begin
		if (!reset)
		begin
			state <= loadRj;
			loadCnt <= '0;
			zeroCnt <= '0;
			sampleIdx <= '0;
			newestIdx <= '0;
			historyFull <= 1'b0;
			pendL <= 1'b0;
			pendR <= 1'b0;
			isHistory <= 1'b0;
			issueSample <= 1'b0;
			newSample <= 1'b0;
			inReady <= 1'b0;
		end
		else
		begin
			inReady <= !start;
			newSample <= 1'b0;
			if (start)
			begin
				state <= loadRj;
				loadCnt <= '0;
				zeroCnt <= '0;
				sampleIdx <= '0;
				historyFull <= 1'b0;
				pendL <= 1'b0;
				pendR <= 1'b0;
			end
			else
			begin
				if (wordValid)
				begin
					pendL <= 1'b1;
					isHistory <= (state == run) || (state == asleep);
					issueSample <= 1'b0;
					case (state)
						loadRj:
						begin
							if (loadCnt == cntW'(numRj - 1))
							begin
								state <= loadCoeff;
								loadCnt <= '0;
							end
							else
								loadCnt <= loadCnt + 1'b1;
						end
						loadCoeff:
						begin
							if (loadCnt == cntW'(numCoeff - 1))
								state <= run;
							loadCnt <= loadCnt + 1'b1;
						end
						default:
						begin
							// Sleep decision on every sample pair
							if (!zeroPair)
							begin
								zeroCnt <= '0;
								state <= run;
								issueSample <= 1'b1;
							end
							else if (zeroCnt >= zeroW'(sleepThreshold - 1))
							begin
								zeroCnt <= zeroW'(sleepThreshold);
								state <= asleep;
							end
							else
							begin
								zeroCnt <= zeroCnt + 1'b1;
								issueSample <= 1'b1;
							end
						end
					endcase
				end
				if (pendL && wrGnt)
				begin
					pendL <= 1'b0;
					pendR <= 1'b1;
				end
				if (pendR && wrGnt)
				begin
					pendR <= 1'b0;
					if (isHistory)
					begin
						newestIdx <= sampleIdx;
						sampleIdx <= sampleIdx + 1'b1;
						if (sampleIdx == 8'hFF)
							historyFull <= 1'b1;
						newSample <= issueSample;
					end
				end
			end
		end
	end

	// Frames must be spaced past both writes and the whole computation
	assert property (@(posedge sClk) disable iff (!reset) wordValid |-> !wrReq)
		else $error("word arrived with a memory write still pending");
	assert property (@(posedge sClk) disable iff (!reset) wordValid |-> !engineBusy)
		else $error("word arrived while the filter engine was busy");

endmodule

// File: hw/memArbiter.sv
`timescale 1ns/1ps

module memArbiter import msdapPkg::*; (
	input logic wrReq,
	input memAddrT wrAddr,
	input sampleT wrData,
	input logic rdReq,
	input memAddrT rdAddr,
	output logic wrGnt,
	output logic rdGnt,
	output memAddrT memAddr,
	output sampleT memWrData,
	output logic memWe
);

	// Writer has fixed priority over the reader
	assign wrGnt = wrReq;
	assign rdGnt = rdReq && !wrReq;

	assign memAddr = wrGnt ? wrAddr : rdAddr;
	assign memWrData = wrData;
	assign memWe = wrGnt;

endmodule

// File: hw/filterMemory.sv
`timescale 1ns/1ps

module filterMemory import msdapPkg::*; (
	input logic sClk,
	input memAddrT memAddr,
	input sampleT memWrData,
	input logic memWe,
	output sampleT memRdData
);

	// Both channels, history, rj and coefficient regions
	sampleT mem [0:2047];

	always_ff @(posedge sClk)
	begin
		if (memWe)
			mem[memAddr] <= memWrData;
		memRdData <= mem[memAddr];
	end

endmodule

// File: hw/potFilterEngine.sv
`timescale 1ns/1ps

module potFilterEngine import msdapPkg::*; #(
	parameter int numRj = 16,
	parameter int numCoeff = 512
) (
	input logic sClk,
	input logic reset,
	input logic start,
	input logic newSample,
	input histIdxT newestIdx,
	input logic historyFull,
	input logic rdGnt,
	input sampleT rdData,
	output logic rdReq,
	output memAddrT rdAddr,
	output logic engineBusy,
	output logic yValid,
	output accT yL,
	output accT yR
);

	localparam int ptrW = $clog2(numCoeff + 1);
	localparam int grpW = $clog2(numRj + 1);

	engineStateT state;
	logic chan;
	logic [grpW-1:0] grp;
	logic [ptrW-1:0] coeffPtr;
	logic [ptrW-1:0] coeffLeft;
	// High in the cycle the RAM returns the granted word
	logic waitData;
	coeffT coeffWord;
	logic [delayWidth-1:0] delay;
	logic neg;
	logic counts;
	histIdxT histIdx;
	memAddrT chanBase;
	accT acc;
	accT sampleExt;

	assign coeffWord = rdData;
	assign counts = (coeffWord[delayWidth-1:0] <= newestIdx) || historyFull;
	assign histIdx = newestIdx - delay;
	// x times 2^16, sign extended to 40 bits
	assign sampleExt = {{8{rdData[15]}}, rdData, 16'h0000};

	assign engineBusy = (state != idle);
	assign rdReq = ((state == fetchRj) || (state == fetchCoeff) || (state == fetchSample))
		&& !waitData;

	always_comb
	begin
		chanBase = chan ? channelStride : '0;
		case (state)
			fetchRj: rdAddr = chanBase + rjBase + memAddrT'(grp);
			fetchCoeff: rdAddr = chanBase + coeffBase + memAddrT'(coeffPtr);
			default: rdAddr = chanBase + historyBase + memAddrT'(histIdx);
		endcase
	end

	////////////////////////////////////////////////////////////
	// Group walk
	////////////////////////////////////////////////////////////

	always_ff @(posedge sClk or negedge reset)
	begin
		if (!reset)
		begin
			state <= idle;
			chan <= 1'b0;
			grp <= '0;
			coeffPtr <= '0;
			coeffLeft <= '0;
			waitData <= 1'b0;
			yValid <= 1'b0;
		end
		else if (start)
		begin
			state <= idle;
			chan <= 1'b0;
			waitData <= 1'b0;
			yValid <= 1'b0;
		end
		else
		begin
			yValid <= 1'b0;
			// rdReq drops while waiting, so no grant can overlap
			waitData <= rdGnt;
			case (state)
				idle:
				begin
					if (newSample)
					begin
						state <= fetchRj;
						chan <= 1'b0;
						grp <= '0;
						coeffPtr <= '0;
					end
				end
				fetchRj:
				begin
					if (waitData)
					begin
						coeffLeft <= rdData[ptrW-1:0];
						state <= (rdData[ptrW-1:0] == '0) ? groupEnd : fetchCoeff;
					end
				end
				fetchCoeff:
				begin
					if (waitData)
					begin
						coeffPtr <= coeffPtr + 1'b1;
						coeffLeft <= coeffLeft - 1'b1;
						// History before the first sample counts as zero
						if (counts)
							state <= fetchSample;
						else if (coeffLeft == ptrW'(1))
							state <= groupEnd;
					end
				end
				fetchSample:
				begin
					if (waitData)
						state <= (coeffLeft == '0) ? groupEnd : fetchCoeff;
				end
				groupEnd:
				begin
					grp <= grp + 1'b1;
					state <= (grp == grpW'(numRj - 1)) ? nextChannel : fetchRj;
				end
				nextChannel:
				begin
					grp <= '0;
					coeffPtr <= '0;
					if (!chan)
					begin
						chan <= 1'b1;
						state <= fetchRj;
					end
					else
					begin
						chan <= 1'b0;
						yValid <= 1'b1;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Accumulator
	////////////////////////////////////////////////////////////

	always_ff @(posedge sClk)
	begin
		case (state)
			idle:
				if (newSample)
					acc <= '0;
			fetchCoeff:
			begin
				if (waitData)
				begin
					delay <= coeffWord[delayWidth-1:0];
					neg <= coeffWord[signBit];
				end
			end
			fetchSample:
				if (waitData)
					acc <= neg ? acc - sampleExt : acc + sampleExt;
			// Arithmetic shift right by one
			groupEnd: acc <= {acc[39], acc[39:1]};
			nextChannel:
			begin
				acc <= '0;
				if (!chan)
					yL <= acc;
				else
					yR <= acc;
			end
			default: acc <= acc;
		endcase
	end

	// The rj counts loaded into the table may not exceed the coefficient count
	assert property (@(posedge sClk) disable iff (!reset)
		(state == fetchCoeff) |-> (coeffPtr < ptrW'(numCoeff)))
		else $error("coefficient pointer ran past numCoeff");

endmodule

// File: hw/outputSerializer.sv
`timescale 1ns/1ps

module outputSerializer import msdapPkg::*; (
	input logic sClk,
	input logic reset,
	input logic start,
	input logic yValid,
	input accT yL,
	input accT yR,
	output logic outReady,
	output logic outputL,
	output logic outputR
);

	logic [5:0] bitCnt;
	accT shiftL;
	accT shiftR;

	assign outReady = (bitCnt != '0);
	// LSB first
	assign outputL = outReady & shiftL[0];
	assign outputR = outReady & shiftR[0];

	always_ff @(posedge sClk or negedge reset)
	begin
		if (!reset)
			bitCnt <= '0;
		else if (start)
			bitCnt <= '0;
		else if (yValid && !outReady)
			bitCnt <= 6'd40;
		else if (outReady)
			bitCnt <= bitCnt - 6'd1;
	end

	// A new word is only taken once the last one is out
	always_ff @(posedge sClk)
	begin
		if (yValid && !outReady)
		begin
			shiftL <= yL;
			shiftR <= yR;
		end
		else if (outReady)
		begin
			shiftL <= shiftL >> 1;
			shiftR <= shiftR >> 1;
		end
	end

endmodule

// File: hw/msdapTop.sv
`timescale 1ns/1ps

module msdapTop import msdapPkg::*; #(
	parameter int numRj = 16,
	parameter int numCoeff = 512,
	parameter int sleepThreshold = 800
) (
	input logic sClk,
	input logic reset,
	input logic start,
	input logic frame,
	input logic inputL,
	input logic inputR,
	output logic inReady,
	output logic outReady,
	output logic outputL,
	output logic outputR
);

	logic wordValid;
	sampleT wordL;
	sampleT wordR;
	logic wrReq;
	logic wrGnt;
	memAddrT wrAddr;
	sampleT wrData;
	logic rdReq;
	logic rdGnt;
	memAddrT rdAddr;
	memAddrT memAddr;
	sampleT memWrData;
	sampleT memRdData;
	logic memWe;
	logic newSample;
	histIdxT newestIdx;
	logic historyFull;
	logic engineBusy;
	logic yValid;
	accT yL;
	accT yR;

	////////////////////////////////////////////////////////////
	// Input side
	////////////////////////////////////////////////////////////

	serialReceiver receiver (
		.sClk(sClk), .reset(reset), .frame(frame), .inputL(inputL), .inputR(inputR),
		.wordValid(wordValid), .wordL(wordL), .wordR(wordR)
	);

	loadSequencer #(.numRj(numRj), .numCoeff(numCoeff), .sleepThreshold(sleepThreshold)) loader (
		.sClk(sClk), .reset(reset), .start(start), .wordValid(wordValid),
		.wordL(wordL), .wordR(wordR), .wrGnt(wrGnt), .engineBusy(engineBusy),
		.inReady(inReady), .wrReq(wrReq), .wrAddr(wrAddr), .wrData(wrData),
		.newSample(newSample), .newestIdx(newestIdx), .historyFull(historyFull)
	);

	////////////////////////////////////////////////////////////
	// Shared memory
	////////////////////////////////////////////////////////////

	memArbiter arbiter (
		.wrReq(wrReq), .wrAddr(wrAddr), .wrData(wrData), .rdReq(rdReq), .rdAddr(rdAddr),
		.wrGnt(wrGnt), .rdGnt(rdGnt), .memAddr(memAddr), .memWrData(memWrData),
		.memWe(memWe)
	);

	filterMemory memory (
		.sClk(sClk), .memAddr(memAddr), .memWrData(memWrData), .memWe(memWe),
		.memRdData(memRdData)
	);

	////////////////////////////////////////////////////////////
	// Compute and output side
	////////////////////////////////////////////////////////////

	potFilterEngine #(.numRj(numRj), .numCoeff(numCoeff)) engine (
		.sClk(sClk), .reset(reset), .start(start), .newSample(newSample),
		.newestIdx(newestIdx), .historyFull(historyFull), .rdGnt(rdGnt),
		.rdData(memRdData), .rdReq(rdReq), .rdAddr(rdAddr), .engineBusy(engineBusy),
		.yValid(yValid), .yL(yL), .yR(yR)
	);

	outputSerializer serializer (
		.sClk(sClk), .reset(reset), .start(start), .yValid(yValid), .yL(yL), .yR(yR),
		.outReady(outReady), .outputL(outputL), .outputR(outputR)
	);

endmodule

// File: bench/msdapTb.sv
`timescale 1ns/1ps

module msdapTb;

	localparam int numRj = 16;
	localparam int numCoeff = 512;
	localparam int sleepThreshold = 800;

	// Most coefficients any test table uses in one channel
	localparam int maxCoeffUsed = 64;
	// Engine cycles per pair: three per group, four per coefficient, both channels
	localparam int computeCycles = 2 * (3 * numRj + 4 * maxCoeffUsed + 2) + 4;
	localparam int outputWait = computeCycles + 40;
	localparam int frameSpacing = 20 + outputWait + 40 + 20;
	localparam int impulsePairs = 16;
	localparam int randomPairs = 300;
	localparam int sleepPairs = sleepThreshold + 10;
	localparam int reloadPairs = 12;
	localparam int totalFrames = 3 * (numRj + numCoeff) + impulsePairs + randomPairs
		+ sleepPairs + 1 + reloadPairs;
	localparam int timeoutCycles = totalFrames * frameSpacing;

	logic sClk;
	logic reset;
	logic start;
	logic frame;
	logic inputL;
	logic inputR;
	logic inReady;
	logic outReady;
	logic outputL;
	logic outputR;

	// Tables as loaded, index 0 is left and 1 is right
	int rjTab [2][numRj];
	logic [15:0] coefTab [2][numCoeff];
	// Samples sent since the last start
	logic [15:0] histL [$];
	logic [15:0] histR [$];
	int zeroRun;
	logic [31:0] lcgState;
	int errorCnt = 0;
	int checkCnt = 0;
	int cycleCnt = 0;

	msdapTop #(.numRj(numRj), .numCoeff(numCoeff), .sleepThreshold(sleepThreshold)) UUT (
		.sClk(sClk), .reset(reset), .start(start), .frame(frame),
		.inputL(inputL), .inputR(inputR), .inReady(inReady), .outReady(outReady),
		.outputL(outputL), .outputR(outputR)
	);

	initial sClk = 1'b0;
	always #4 sClk = ~sClk;

	always @(posedge sClk)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= timeoutCycles)
		begin
			$display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
			$display("Checks: %0d, errors: %0d", checkCnt, errorCnt);
			$display("tests failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	function automatic logic [15:0] randomWord();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[31:16];
	endfunction

	// Delay in bits 7..0, sign in bit 8
	function automatic logic [15:0] packCoeff(input logic [7:0] delay, input logic neg);
		return {7'b0, neg, delay};
	endfunction

	task automatic compareValue(input string what, input logic [39:0] got,
		input logic [39:0] expected);
		checkCnt++;
		assert (got === expected)
		else
		begin
			errorCnt++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic requireTrue(input logic cond, input string message);
		checkCnt++;
		assert (cond)
		else
		begin
			errorCnt++;
			$display("%s (at %0t ns)", message, $time);
		end
	endtask

	// U = (U + group sum) >>> 1 over all groups, missing history is zero
	function automatic logic signed [39:0] filterModel(input int ch);
		logic signed [39:0] u;
		logic signed [39:0] groupSum;
		logic signed [39:0] term;
		logic signed [15:0] x;
		logic [15:0] c;
		int n;
		int p;
		int j;
		int i;
		int k;
		u = '0;
		p = 0;
		n = (ch == 0) ? histL.size() - 1 : histR.size() - 1;
		for (j = 0; j < numRj; j++)
		begin
			groupSum = '0;
			for (i = 0; i < rjTab[ch][j]; i++)
			begin
				c = coefTab[ch][p];
				p++;
				k = int'(c[7:0]);
				if (k <= n)
				begin
					x = (ch == 0) ? histL[n - k] : histR[n - k];
					term = 40'(x);
					term = term * 40'sd65536;
					groupSum = c[8] ? groupSum - term : groupSum + term;
				end
			end
			u = (u + groupSum) >>> 1;
		end
		return u;
	endfunction

	////////////////////////////////////////////////////////////
	// Serial drive and capture
	////////////////////////////////////////////////////////////

	task automatic sendPair(input logic [15:0] l, input logic [15:0] r);
		int b;
		for (b = 15; b >= 0; b--)
		begin
			@(negedge sClk);
			frame = (b == 15);
			inputL = l[b];
			inputR = r[b];
		end
		@(negedge sClk);
		frame = 1'b0;
		inputL = 1'b0;
		inputR = 1'b0;
	endtask

	task automatic getOutput(output logic [39:0] gotL, output logic [39:0] gotR,
		output logic seen);
		int waited;
		int b;
		logic dropped;
		gotL = '0;
		gotR = '0;
		waited = 0;
		dropped = 1'b0;
		while (!outReady && waited < outputWait)
		begin
			@(negedge sClk);
			waited++;
		end
		seen = outReady;
		if (seen)
		begin
			// LSB first, one bit per cycle
			for (b = 0; b < 40; b++)
			begin
				if (!outReady)
					dropped = 1'b1;
				gotL[b] = outputL;
				gotR[b] = outputR;
				@(negedge sClk);
			end
			requireTrue(!dropped, "outReady fell before all 40 bits were sent");
			requireTrue(!outReady, "outReady stayed high after 40 bits");
		end
	endtask

	task automatic waitQuiet();
		int n;
		logic burst;
		burst = 1'b0;
		for (n = 0; n < outputWait + 40; n++)
		begin
			@(negedge sClk);
			if (outReady)
				burst = 1'b1;
		end
		requireTrue(!burst, "An output word appeared while the filter should sleep");
	endtask

	task automatic pulseStart();
		@(negedge sClk);
		start = 1'b1;
		@(negedge sClk);
		start = 1'b0;
		compareValue("inReady after start", 40'(inReady), 40'd0);
		@(negedge sClk);
		compareValue("inReady", 40'(inReady), 40'd1);
		histL.delete();
		histR.delete();
		zeroRun = 0;
	endtask

	// Unused coefficients go out as zeros
	task automatic loadTables();
		int j;
		int p;
		for (j = 0; j < numRj; j++)
			sendPair(16'(rjTab[0][j]), 16'(rjTab[1][j]));
		for (p = 0; p < numCoeff; p++)
			sendPair(coefTab[0][p], coefTab[1][p]);
	endtask

	// One sample pair with its expected response
	task automatic stepPair(input logic [15:0] l, input logic [15:0] r);
		logic expectOut;
		logic signed [39:0] expL;
		logic signed [39:0] expR;
		logic [39:0] gotL;
		logic [39:0] gotR;
		logic seen;
		histL.push_back(l);
		histR.push_back(r);
		if (l == 16'd0 && r == 16'd0)
		begin
			if (zeroRun < sleepThreshold)
				zeroRun++;
		end
		else
			zeroRun = 0;
		// Asleep once the zero run reaches the threshold
		expectOut = (zeroRun < sleepThreshold);
		expL = filterModel(0);
		expR = filterModel(1);
		sendPair(l, r);
		if (expectOut)
		begin
			getOutput(gotL, gotR, seen);
			requireTrue(seen, "No output word arrived for a sample pair");
			if (seen)
			begin
				compareValue("left output", gotL, expL);
				compareValue("right output", gotR, expR);
			end
		end
		else
			waitQuiet();
	endtask

	////////////////////////////////////////////////////////////
	// Table sets
	////////////////////////////////////////////////////////////

	task automatic clearTables();
		int ch;
		int i;
		for (ch = 0; ch < 2; ch++)
		begin
			for (i = 0; i < numRj; i++)
				rjTab[ch][i] = 0;
			for (i = 0; i < numCoeff; i++)
				coefTab[ch][i] = '0;
		end
	endtask

	task automatic impulseTables();
		clearTables();
		// Left uses groups 0..3, group 2 empty
		rjTab[0][0] = 2;
		rjTab[0][1] = 1;
		rjTab[0][3] = 3;
		coefTab[0][0] = packCoeff(8'd0, 1'b0);
		coefTab[0][1] = packCoeff(8'd2, 1'b1);
		coefTab[0][2] = packCoeff(8'd1, 1'b0);
		coefTab[0][3] = packCoeff(8'd3, 1'b1);
		coefTab[0][4] = packCoeff(8'd0, 1'b0);
		coefTab[0][5] = packCoeff(8'd5, 1'b0);
		rjTab[1][0] = 1;
		rjTab[1][1] = 2;
		rjTab[1][5] = 1;
		coefTab[1][0] = packCoeff(8'd1, 1'b1);
		coefTab[1][1] = packCoeff(8'd0, 1'b0);
		coefTab[1][2] = packCoeff(8'd4, 1'b1);
		coefTab[1][3] = packCoeff(8'd2, 1'b0);
	endtask

	task automatic randomTables();
		int ch;
		int j;
		int i;
		int p;
		logic [15:0] r;
		clearTables();
		for (ch = 0; ch < 2; ch++)
		begin
			p = 0;
			for (j = 0; j < numRj; j++)
			begin
				r = randomWord();
				rjTab[ch][j] = (j == 0) ? 2 : int'(r[9:8]);
				for (i = 0; i < rjTab[ch][j]; i++)
				begin
					r = randomWord();
					coefTab[ch][p] = packCoeff(r[7:0], r[12]);
					p++;
				end
			end
			// Deepest and newest taps always present
			coefTab[ch][0] = packCoeff(8'd255, 1'b0);
			coefTab[ch][1] = packCoeff(8'd0, 1'b1);
		end
	endtask

	task automatic reloadTables();
		clearTables();
		rjTab[0][0] = 1;
		rjTab[0][15] = 2;
		coefTab[0][0] = packCoeff(8'd0, 1'b1);
		coefTab[0][1] = packCoeff(8'd1, 1'b0);
		coefTab[0][2] = packCoeff(8'd3, 1'b0);
		rjTab[1][7] = 3;
		rjTab[1][8] = 1;
		coefTab[1][0] = packCoeff(8'd0, 1'b0);
		coefTab[1][1] = packCoeff(8'd1, 1'b0);
		coefTab[1][2] = packCoeff(8'd2, 1'b1);
		coefTab[1][3] = packCoeff(8'd6, 1'b0);
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic testReset();
		int n;
		for (n = 0; n < 8; n++)
		begin
			@(negedge sClk);
			compareValue("outReady in reset", 40'(outReady), 40'd0);
			compareValue("inReady in reset", 40'(inReady), 40'd0);
		end
		reset = 1'b1;
		@(negedge sClk);
		compareValue("inReady after reset", 40'(inReady), 40'd1);
		compareValue("outReady after reset", 40'(outReady), 40'd0);
	endtask

	task automatic testImpulse();
		int n;
		impulseTables();
		pulseStart();
		loadTables();
		stepPair(16'd1000, 16'(-300));
		for (n = 0; n < 7; n++)
			stepPair(16'd0, 16'd0);
		// Right only, left must stay quiet
		stepPair(16'd0, 16'd700);
		for (n = 0; n < 7; n++)
			stepPair(16'd0, 16'd0);
	endtask

	task automatic testRandom();
		int n;
		randomTables();
		pulseStart();
		loadTables();
		for (n = 0; n < randomPairs; n++)
			stepPair(randomWord(), randomWord());
	endtask

	task automatic testSleep();
		int n;
		for (n = 0; n < sleepPairs; n++)
			stepPair(16'd0, 16'd0);
		stepPair(randomWord() | 16'd1, randomWord());
	endtask

	task automatic testReload();
		int n;
		reloadTables();
		pulseStart();
		loadTables();
		for (n = 0; n < reloadPairs; n++)
			stepPair(randomWord(), randomWord());
	endtask

	initial
	begin
		reset = 1'b0;
		start = 1'b0;
		frame = 1'b0;
		inputL = 1'b0;
		inputR = 1'b0;
		lcgState = 32'hf872;
		zeroRun = 0;
		testReset();
		testImpulse();
		testRandom();
		testSleep();
		testReload();
		$display("Checks: %0d, errors: %0d", checkCnt, errorCnt);
		if (errorCnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: vlog.f
hw/msdapPkg.sv
hw/serialReceiver.sv
hw/loadSequencer.sv
hw/memArbiter.sv
hw/filterMemory.sv
hw/potFilterEngine.sv
hw/outputSerializer.sv
hw/msdapTop.sv
bench/msdapTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module msdapTb -Mdir obj_dir -f vlog.f
	out=$$(./obj_dir/VmsdapTb); echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
